/* src/rv_core_pkg.sv */
package rv_core_pkg;

  // Datapath and register file sizes
  localparam int XLEN           = 32;
  localparam int INST_WIDTH     = 32;
  localparam int NUM_REGS       = 32;
  localparam int REG_ADDR_WIDTH = $clog2(NUM_REGS);

  typedef logic [XLEN-1:0]           xlen_t;
  typedef logic [INST_WIDTH-1:0]     inst_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [3:0]                alu_op_t;

  // ALU operations
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // Operand B straight through, used by LUI
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // Major opcodes kept by this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct7 selecting SUB and SRA
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

/* src/rv_dec_ex_if.sv */
`timescale 1ns/1ps

interface rv_dec_ex_if;

  logic                   valid;
  rv_core_pkg::alu_op_t   alu_op;
  logic                   b_is_imm;
  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::reg_addr_t rs2_addr;
  rv_core_pkg::xlen_t     rs1_data;
  rv_core_pkg::xlen_t     rs2_data;
  rv_core_pkg::xlen_t     imm;
  rv_core_pkg::reg_addr_t rd_addr;
  logic                   rd_we;
  logic                   illegal;

  modport decode_mp (
    output valid, alu_op, b_is_imm, rs1_addr, rs2_addr,
    output rs1_data, rs2_data, imm, rd_addr, rd_we, illegal
  );

  modport execute_mp (
    input valid, alu_op, b_is_imm, rs1_addr, rs2_addr,
    input rs1_data, rs2_data, imm, rd_addr, rd_we, illegal
  );

endinterface

/* src/rv_ex_res_if.sv */
`timescale 1ns/1ps

interface rv_ex_res_if;

  logic                   valid;
  rv_core_pkg::reg_addr_t rd_addr;
  logic                   rd_we;
  rv_core_pkg::xlen_t     data;
  logic                   illegal;

  modport execute_mp (
    output valid, rd_addr, rd_we, data, illegal
  );

  modport result_mp (
    input valid, rd_addr, rd_we, data, illegal
  );

endinterface

/* src/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  rv_core_pkg::reg_addr_t i_rs1_addr,
  input  rv_core_pkg::reg_addr_t i_rs2_addr,
  output rv_core_pkg::xlen_t     o_rs1_data,
  output rv_core_pkg::xlen_t     o_rs2_data,
  input  logic                   i_we,
  input  rv_core_pkg::reg_addr_t i_waddr,
  input  rv_core_pkg::xlen_t     i_wdata
);

  // Storage for x1 to x31 only
  rv_core_pkg::xlen_t regs [1:rv_core_pkg::NUM_REGS-1];

  always_ff @(posedge i_clk) begin
    for (int i = 1; i < rv_core_pkg::NUM_REGS; i++) begin
      if (i_rst) begin
        regs[i] <= '0;
      end else if (i_we && (i_waddr == rv_core_pkg::reg_addr_t'(i))) begin
        regs[i] <= i_wdata;
      end
    end
  end

  // x0 reads zero
  // A write in the same cycle passes straight through
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                      (i_we && (i_waddr == i_rs1_addr)) ? i_wdata : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                      (i_we && (i_waddr == i_rs2_addr)) ? i_wdata : regs[i_rs2_addr];

endmodule

/* src/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_inst_valid,
  input  rv_core_pkg::inst_t     i_inst,
  output rv_core_pkg::reg_addr_t o_rs1_addr,
  output rv_core_pkg::reg_addr_t o_rs2_addr,
  input  rv_core_pkg::xlen_t     i_rs1_data,
  input  rv_core_pkg::xlen_t     i_rs2_data,
  rv_dec_ex_if.decode_mp         o_dec
);

  rv_core_pkg::inst_t     inst_q;
  logic                   valid_q;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  rv_core_pkg::reg_addr_t rd_addr;
  rv_core_pkg::alu_op_t   alu_op;
  logic                   b_is_imm;
  logic                   illegal;
  rv_core_pkg::xlen_t     imm;

  // Shared funct3 map for OP and OP-IMM, alt picks SUB/SRA
  function automatic rv_core_pkg::alu_op_t funct3_op(input logic [2:0] f3, input logic alt);
    rv_core_pkg::alu_op_t op;
    case (f3)
      3'b000:  op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  op = rv_core_pkg::ALU_SLL;
      3'b010:  op = rv_core_pkg::ALU_SLT;
      3'b011:  op = rv_core_pkg::ALU_SLTU;
      3'b100:  op = rv_core_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  op = rv_core_pkg::ALU_OR;
      default: op = rv_core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_inst_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      inst_q <= i_inst;
    end
  end

  assign opcode  = inst_q[6:0];
  assign funct3  = inst_q[14:12];
  assign funct7  = inst_q[31:25];
  assign rd_addr = inst_q[11:7];

  always_comb begin
    alu_op   = rv_core_pkg::ALU_ADD;
    b_is_imm = 1'b0;
    illegal  = 1'b0;
    // I-type immediate unless LUI overrides
    imm      = {{(rv_core_pkg::XLEN-12){inst_q[31]}}, inst_q[31:20]};
    case (opcode)
      rv_core_pkg::OPC_OP: begin
        alu_op = funct3_op(funct3, funct7 == rv_core_pkg::FUNCT7_ALT);
        if (funct7 == rv_core_pkg::FUNCT7_ALT) begin
          illegal = !((funct3 == 3'b000) || (funct3 == 3'b101));
        end else begin
          illegal = (funct7 != 7'b0);
        end
      end
      rv_core_pkg::OPC_OP_IMM: begin
        b_is_imm = 1'b1;
        // Only shifts look at funct7, bit 30 of ADDI is immediate
        alu_op   = funct3_op(funct3, (funct3 == 3'b101) && (funct7 == rv_core_pkg::FUNCT7_ALT));
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'b0);
        end else if (funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0) && (funct7 != rv_core_pkg::FUNCT7_ALT);
        end
      end
      rv_core_pkg::OPC_LUI: begin
        b_is_imm = 1'b1;
        alu_op   = rv_core_pkg::ALU_PASS_B;
        imm      = {inst_q[31:12], 12'b0};
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // LUI reads x0 so it never forwards a stale rs1
  assign o_rs1_addr = (opcode == rv_core_pkg::OPC_LUI) ? '0 : inst_q[19:15];
  assign o_rs2_addr = inst_q[24:20];

  assign o_dec.valid    = valid_q;
  assign o_dec.alu_op   = alu_op;
  assign o_dec.b_is_imm = b_is_imm;
  assign o_dec.rs1_addr = o_rs1_addr;
  assign o_dec.rs2_addr = o_rs2_addr;
  assign o_dec.rs1_data = i_rs1_data;
  assign o_dec.rs2_data = i_rs2_data;
  assign o_dec.imm      = imm;
  assign o_dec.rd_addr  = rd_addr;
  // No write to x0 or from a bad encoding
  assign o_dec.rd_we    = !illegal && (rd_addr != '0);
  assign o_dec.illegal  = illegal;

endmodule

/* src/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  logic                   i_clk,
  input  logic                   i_rst,
  rv_dec_ex_if.execute_mp        i_dec,
  input  logic                   i_fwd_we,
  input  rv_core_pkg::reg_addr_t i_fwd_addr,
  input  rv_core_pkg::xlen_t     i_fwd_data,
  rv_ex_res_if.execute_mp        o_ex
);

  logic                   valid_q;
  rv_core_pkg::alu_op_t   alu_op_q;
  logic                   b_is_imm_q;
  rv_core_pkg::reg_addr_t rs1_addr_q;
  rv_core_pkg::reg_addr_t rs2_addr_q;
  rv_core_pkg::xlen_t     rs1_data_q;
  rv_core_pkg::xlen_t     rs2_data_q;
  rv_core_pkg::xlen_t     imm_q;
  rv_core_pkg::reg_addr_t rd_addr_q;
  logic                   rd_we_q;
  logic                   illegal_q;
  rv_core_pkg::xlen_t     op_a;
  rv_core_pkg::xlen_t     rs2_val;
  rv_core_pkg::xlen_t     op_b;
  logic [4:0]             shamt;
  rv_core_pkg::xlen_t     alu_out;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_dec.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    alu_op_q   <= i_dec.alu_op;
    b_is_imm_q <= i_dec.b_is_imm;
    rs1_addr_q <= i_dec.rs1_addr;
    rs2_addr_q <= i_dec.rs2_addr;
    rs1_data_q <= i_dec.rs1_data;
    rs2_data_q <= i_dec.rs2_data;
    imm_q      <= i_dec.imm;
    rd_addr_q  <= i_dec.rd_addr;
    rd_we_q    <= i_dec.rd_we;
    illegal_q  <= i_dec.illegal;
  end

  // Previous instruction's result, x0 never has fwd_we set
  assign op_a    = (i_fwd_we && (i_fwd_addr == rs1_addr_q)) ? i_fwd_data : rs1_data_q;
  assign rs2_val = (i_fwd_we && (i_fwd_addr == rs2_addr_q)) ? i_fwd_data : rs2_data_q;
  assign op_b    = b_is_imm_q ? imm_q : rs2_val;
  assign shamt   = op_b[4:0];

  always_comb begin
    case (alu_op_q)
      rv_core_pkg::ALU_ADD:    alu_out = op_a + op_b;
      rv_core_pkg::ALU_SUB:    alu_out = op_a - op_b;
      rv_core_pkg::ALU_SLL:    alu_out = op_a << shamt;
      rv_core_pkg::ALU_SLT:    alu_out = rv_core_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      rv_core_pkg::ALU_SLTU:   alu_out = rv_core_pkg::xlen_t'(op_a < op_b);
      rv_core_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:    alu_out = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
      rv_core_pkg::ALU_OR:     alu_out = op_a | op_b;
      rv_core_pkg::ALU_AND:    alu_out = op_a & op_b;
      rv_core_pkg::ALU_PASS_B: alu_out = op_b;
      default:                 alu_out = '0;
    endcase
  end

  assign o_ex.valid   = valid_q;
  assign o_ex.rd_addr = rd_addr_q;
  assign o_ex.rd_we   = rd_we_q;
  // Illegal instructions retire with zero data
  assign o_ex.data    = illegal_q ? '0 : alu_out;
  assign o_ex.illegal = illegal_q;

endmodule

/* src/rv_result.sv */
`timescale 1ns/1ps

module rv_result (
  input  logic                   i_clk,
  input  logic                   i_rst,
  rv_ex_res_if.result_mp         i_ex,
  output logic                   o_rf_we,
  output rv_core_pkg::reg_addr_t o_rf_waddr,
  output rv_core_pkg::xlen_t     o_rf_wdata,
  output logic                   o_fwd_we,
  output rv_core_pkg::reg_addr_t o_fwd_addr,
  output rv_core_pkg::xlen_t     o_fwd_data,
  output logic                   o_retire_valid,
  output rv_core_pkg::reg_addr_t o_retire_rd,
  output rv_core_pkg::xlen_t     o_retire_data,
  output logic                   o_retire_we,
  output logic                   o_retire_illegal
);

  logic                   valid_q;
  rv_core_pkg::reg_addr_t rd_addr_q;
  logic                   rd_we_q;
  rv_core_pkg::xlen_t     data_q;
  logic                   illegal_q;
  logic                   we;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_ex.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    rd_addr_q <= i_ex.rd_addr;
    rd_we_q   <= i_ex.rd_we;
    data_q    <= i_ex.data;
    illegal_q <= i_ex.illegal;
  end

  // Bubbles never write
  assign we = valid_q && rd_we_q;

  // Writeback port, commits at the next edge
  assign o_rf_we    = we;
  assign o_rf_waddr = rd_addr_q;
  assign o_rf_wdata = data_q;

  // Same copy feeds execute
  assign o_fwd_we   = we;
  assign o_fwd_addr = rd_addr_q;
  assign o_fwd_data = data_q;

  assign o_retire_valid   = valid_q;
  assign o_retire_rd      = rd_addr_q;
  assign o_retire_data    = data_q;
  assign o_retire_we      = we;
  assign o_retire_illegal = valid_q && illegal_q;

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_inst_valid,
  input  rv_core_pkg::inst_t     i_inst,
  output logic                   o_retire_valid,
  output rv_core_pkg::reg_addr_t o_retire_rd,
  output rv_core_pkg::xlen_t     o_retire_data,
  output logic                   o_retire_we,
  output logic                   o_retire_illegal
);

  // Register read, decode side
  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::reg_addr_t rs2_addr;
  rv_core_pkg::xlen_t     rs1_data;
  rv_core_pkg::xlen_t     rs2_data;

  // Register write, result side
  logic                   rf_we;
  rv_core_pkg::reg_addr_t rf_waddr;
  rv_core_pkg::xlen_t     rf_wdata;

  // Result stage back into execute
  logic                   fwd_we;
  rv_core_pkg::reg_addr_t fwd_addr;
  rv_core_pkg::xlen_t     fwd_data;

  rv_dec_ex_if dec_ex ();
  rv_ex_res_if ex_res ();

  rv_decode u_decode (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_rs1_addr   (rs1_addr),
    .o_rs2_addr   (rs2_addr),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_dec        (dec_ex.decode_mp)
  );

  rv_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (rf_we),
    .i_waddr    (rf_waddr),
    .i_wdata    (rf_wdata)
  );

  rv_execute u_execute (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_dec      (dec_ex.execute_mp),
    .i_fwd_we   (fwd_we),
    .i_fwd_addr (fwd_addr),
    .i_fwd_data (fwd_data),
    .o_ex       (ex_res.execute_mp)
  );

  rv_result u_result (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_ex             (ex_res.result_mp),
    .o_rf_we          (rf_we),
    .o_rf_waddr       (rf_waddr),
    .o_rf_wdata       (rf_wdata),
    .o_fwd_we         (fwd_we),
    .o_fwd_addr       (fwd_addr),
    .o_fwd_data       (fwd_data),
    .o_retire_valid   (o_retire_valid),
    .o_retire_rd      (o_retire_rd),
    .o_retire_data    (o_retire_data),
    .o_retire_we      (o_retire_we),
    .o_retire_illegal (o_retire_illegal)
  );

endmodule

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam int RETIRE_CYCLE  = 3;
  localparam int DRAIN_TIMEOUT = 50;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [6:0] ALT     = rv_core_pkg::FUNCT7_ALT;

  logic                   i_clk = 1'b0;
  logic                   i_rst;
  logic                   i_inst_valid;
  rv_core_pkg::inst_t     i_inst;
  logic                   o_retire_valid;
  rv_core_pkg::reg_addr_t o_retire_rd;
  rv_core_pkg::xlen_t     o_retire_data;
  logic                   o_retire_we;
  logic                   o_retire_illegal;

  // Architectural state in program order
  rv_core_pkg::xlen_t ref_regs [32];

  // Expected retirements, oldest first
  rv_core_pkg::inst_t     exp_inst [$];
  rv_core_pkg::reg_addr_t exp_rd [$];
  rv_core_pkg::xlen_t     exp_data [$];
  logic                   exp_we [$];
  logic                   exp_illegal [$];
  int                     exp_edge [$];

  rv_core_pkg::inst_t     mon_inst;
  rv_core_pkg::reg_addr_t mon_rd;
  rv_core_pkg::xlen_t     mon_data;
  logic                   mon_we;
  logic                   mon_illegal;
  int                     mon_edge;

  int     cycle_count = 0;
  int     errors = 0;
  int     retired = 0;
  integer seed = 96000;

  rv_core uut (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_inst_valid     (i_inst_valid),
    .i_inst           (i_inst),
    .o_retire_valid   (o_retire_valid),
    .o_retire_rd      (o_retire_rd),
    .o_retire_data    (o_retire_data),
    .o_retire_we      (o_retire_we),
    .o_retire_illegal (o_retire_illegal)
  );

  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_data(input rv_core_pkg::xlen_t got, input rv_core_pkg::xlen_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_rd(input rv_core_pkg::reg_addr_t got,
                          input rv_core_pkg::reg_addr_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s, got x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("FAILED at %0t ns: %s, got cycle %0d, expected cycle %0d",
               $time, what, got, exp);
    end
  endtask

  function automatic rv_core_pkg::inst_t enc_r(input logic [6:0] f7,
      input rv_core_pkg::reg_addr_t rs2, input rv_core_pkg::reg_addr_t rs1,
      input logic [2:0] f3, input rv_core_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
  endfunction

  function automatic rv_core_pkg::inst_t enc_i(input logic [11:0] imm,
      input rv_core_pkg::reg_addr_t rs1, input logic [2:0] f3,
      input rv_core_pkg::reg_addr_t rd);
    return {imm, rs1, f3, rd, rv_core_pkg::OPC_OP_IMM};
  endfunction

  function automatic rv_core_pkg::inst_t enc_lui(input logic [19:0] imm,
      input rv_core_pkg::reg_addr_t rd);
    return {imm, rd, rv_core_pkg::OPC_LUI};
  endfunction

  // RV32I integer semantics, alt selects SUB and SRA
  function automatic rv_core_pkg::xlen_t alu_ref(input logic [2:0] f3, input logic alt,
      input rv_core_pkg::xlen_t a, input rv_core_pkg::xlen_t b);
    rv_core_pkg::xlen_t r;
    case (f3)
      F3_ADD:  r = alt ? (a - b) : (a + b);
      F3_SLL:  r = a << b[4:0];
      F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  r = a ^ b;
      F3_SR: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      F3_OR:   r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic model_step(input rv_core_pkg::inst_t inst, output rv_core_pkg::xlen_t data,
                            output logic we, output logic illegal);
    logic [6:0]             opc;
    logic [6:0]             f7;
    logic [2:0]             f3;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::xlen_t     a;
    rv_core_pkg::xlen_t     b;
    rv_core_pkg::xlen_t     imm_i;
    opc     = inst[6:0];
    rd      = inst[11:7];
    f3      = inst[14:12];
    f7      = inst[31:25];
    a       = ref_regs[inst[19:15]];
    b       = ref_regs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    data    = '0;
    illegal = 1'b0;
    case (opc)
      rv_core_pkg::OPC_OP: begin
        if (f7 == 7'b0) begin
          data = alu_ref(f3, 1'b0, a, b);
        end else if ((f7 == ALT) && ((f3 == F3_ADD) || (f3 == F3_SR))) begin
          data = alu_ref(f3, 1'b1, a, b);
        end else begin
          illegal = 1'b1;
        end
      end
      rv_core_pkg::OPC_OP_IMM: begin
        if ((f3 == F3_SLL) && (f7 != 7'b0)) begin
          illegal = 1'b1;
        end else if ((f3 == F3_SR) && (f7 != 7'b0) && (f7 != ALT)) begin
          illegal = 1'b1;
        end else begin
          data = alu_ref(f3, (f3 == F3_SR) && (f7 == ALT), a, imm_i);
        end
      end
      rv_core_pkg::OPC_LUI: data = {inst[31:12], 12'b0};
      default: illegal = 1'b1;
    endcase
    we = !illegal && (rd != 5'd0);
    if (we) begin
      ref_regs[rd] = data;
    end
  endtask

  task automatic end_run();
    $display("Retirements checked: %0d, errors: %0d", retired, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // Drive one instruction, it is sampled at the next edge
  task automatic issue(input rv_core_pkg::inst_t inst);
    rv_core_pkg::xlen_t data;
    logic               we;
    logic               illegal;
    @(posedge i_clk);
    #2;
    i_inst_valid = 1'b1;
    i_inst       = inst;
    model_step(inst, data, we, illegal);
    exp_inst.push_back(inst);
    exp_rd.push_back(inst[11:7]);
    exp_data.push_back(data);
    exp_we.push_back(we);
    exp_illegal.push_back(illegal);
    exp_edge.push_back(cycle_count + 1);
  endtask

  // Bubbles carry junk on the instruction bus
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #2;
      i_inst_valid = 1'b0;
      i_inst       = $random(seed);
    end
  endtask

  task automatic drain();
    int waited;
    idle(1);
    waited = 0;
    while ((exp_rd.size() != 0) && (waited < DRAIN_TIMEOUT)) begin
      @(posedge i_clk);
      waited++;
    end
    if (exp_rd.size() != 0) begin
      $display("Timeout: %0d instructions never retired", exp_rd.size());
      errors++;
      end_run();
    end
  endtask

  always @(negedge i_clk) begin
    if (cycle_count > 0) begin
      if (o_retire_valid === 1'b1) begin
        if (i_rst) begin
          errors++;
          $display("Retirement seen during reset at %0t ns", $time);
        end else if (exp_rd.size() == 0) begin
          errors++;
          $display("Retirement at %0t ns with no instruction outstanding", $time);
        end else begin
          mon_inst    = exp_inst.pop_front();
          mon_rd      = exp_rd.pop_front();
          mon_data    = exp_data.pop_front();
          mon_we      = exp_we.pop_front();
          mon_illegal = exp_illegal.pop_front();
          mon_edge    = exp_edge.pop_front();
          check_rd(o_retire_rd, mon_rd, $sformatf("rd of %h", mon_inst));
          check_data(o_retire_data, mon_data, $sformatf("data of %h", mon_inst));
          check_flag(o_retire_we, mon_we, $sformatf("we of %h", mon_inst));
          check_flag(o_retire_illegal, mon_illegal, $sformatf("illegal of %h", mon_inst));
          check_latency(cycle_count - mon_edge + 1, RETIRE_CYCLE,
                        $sformatf("retire cycle of %h", mon_inst));
          retired++;
        end
      end else if (o_retire_valid !== 1'b0) begin
        errors++;
        $display("o_retire_valid is unknown at %0t ns", $time);
      end
    end
  end

  // 8 cycles in reset, then idle, 20 cycles in all
  task automatic reset_quiet();
    for (int i = 0; i < 20; i++) begin
      @(posedge i_clk);
      #2;
      if (i == 7) begin
        i_rst = 1'b0;
      end
      @(negedge i_clk);
      check_flag(o_retire_valid, 1'b0, "retire valid with no strobe");
    end
  endtask

  task automatic imm_and_lui_ops();
    issue(enc_lui(20'h12345, 5'd1));
    issue(enc_i(12'h678, 5'd1, F3_ADD, 5'd1));
    issue(enc_i(12'hFFB, 5'd0, F3_ADD, 5'd2));
    idle(1);
    issue(enc_i(12'hFFD, 5'd2, F3_SLT, 5'd3));
    issue(enc_i(12'h005, 5'd2, F3_SLTU, 5'd4));
    issue(enc_i(12'hFFF, 5'd1, F3_XOR, 5'd5));
    issue(enc_i(12'h0F0, 5'd2, F3_OR, 5'd6));
    issue(enc_i(12'h0FF, 5'd1, F3_AND, 5'd7));
    issue(enc_i({7'b0, 5'd4}, 5'd1, F3_SLL, 5'd8));
    issue(enc_i({7'b0, 5'd3}, 5'd2, F3_SR, 5'd9));
    issue(enc_i({ALT, 5'd2}, 5'd2, F3_SR, 5'd10));
    drain();
  endtask

  task automatic reg_reg_ops();
    issue(enc_i(12'hFEC, 5'd0, F3_ADD, 5'd11));
    issue(enc_i(12'h003, 5'd0, F3_ADD, 5'd12));
    issue(enc_lui(20'h80000, 5'd13));
    idle(2);
    issue(enc_r(7'b0, 5'd12, 5'd11, F3_ADD, 5'd14));
    issue(enc_r(ALT, 5'd11, 5'd12, F3_ADD, 5'd15));
    issue(enc_r(7'b0, 5'd12, 5'd12, F3_SLL, 5'd16));
    issue(enc_r(7'b0, 5'd12, 5'd11, F3_SLT, 5'd17));
    issue(enc_r(7'b0, 5'd12, 5'd11, F3_SLTU, 5'd18));
    issue(enc_r(7'b0, 5'd13, 5'd11, F3_XOR, 5'd19));
    issue(enc_r(7'b0, 5'd12, 5'd13, F3_SR, 5'd20));
    issue(enc_r(ALT, 5'd12, 5'd11, F3_SR, 5'd21));
    issue(enc_r(ALT, 5'd12, 5'd13, F3_SR, 5'd22));
    issue(enc_r(7'b0, 5'd13, 5'd11, F3_OR, 5'd23));
    issue(enc_r(7'b0, 5'd12, 5'd11, F3_AND, 5'd24));
    issue(enc_r(ALT, 5'd12, 5'd11, F3_ADD, 5'd26));
    // Write to x0, then read it back
    issue(enc_r(7'b0, 5'd12, 5'd11, F3_ADD, 5'd0));
    issue(enc_r(7'b0, 5'd12, 5'd0, F3_ADD, 5'd25));
    drain();
  endtask

  task automatic dependence_chains();
    issue(enc_i(12'h001, 5'd0, F3_ADD, 5'd1));
    issue(enc_r(7'b0, 5'd1, 5'd1, F3_ADD, 5'd2));
    issue(enc_r(7'b0, 5'd1, 5'd2, F3_ADD, 5'd3));
    issue(enc_r(ALT, 5'd2, 5'd3, F3_ADD, 5'd4));
    issue(enc_r(7'b0, 5'd3, 5'd4, F3_XOR, 5'd5));
    issue(enc_r(7'b0, 5'd4, 5'd5, F3_SLL, 5'd6));
    repeat (5) begin
      issue(enc_i(12'h001, 5'd7, F3_ADD, 5'd7));
    end
    // Newest of two writes to x8 must win
    issue(enc_i(12'h005, 5'd0, F3_ADD, 5'd8));
    issue(enc_i(12'h009, 5'd0, F3_ADD, 5'd8));
    issue(enc_r(7'b0, 5'd8, 5'd8, F3_ADD, 5'd9));
    drain();
  endtask

  task automatic illegal_encodings();
    issue({12'h004, 5'd2, 3'b010, 5'd1, 7'b0000011});
    issue(enc_r(7'b0000001, 5'd12, 5'd11, F3_ADD, 5'd1));
    issue(enc_i({ALT, 5'd3}, 5'd11, F3_SLL, 5'd1));
    issue(enc_r(7'b0, 5'd0, 5'd1, F3_ADD, 5'd2));
    issue(enc_r(7'b0, 5'd1, 5'd1, F3_ADD, 5'd3));
    drain();
  endtask

  task automatic random_stream();
    logic [31:0]            rnd;
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::reg_addr_t rs1;
    rv_core_pkg::reg_addr_t rs2;
    logic [2:0]             f3;
    logic                   alt;
    logic [11:0]            imm;
    for (int n = 0; n < 200; n++) begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
        idle(1 + rnd[2]);
      end
      rnd = $random(seed);
      // Low registers only, so hazards are frequent
      rd  = {1'b0, rnd[3:0]};
      rs1 = {1'b0, rnd[7:4]};
      rs2 = {1'b0, rnd[11:8]};
      f3  = rnd[14:12];
      alt = rnd[15] && ((f3 == F3_ADD) || (f3 == F3_SR));
      if (rnd[18:16] < 3'd4) begin
        issue(enc_r(alt ? ALT : 7'b0, rs2, rs1, f3, rd));
      end else if (rnd[18:16] < 3'd7) begin
        if (f3 == F3_SLL) begin
          imm = {7'b0, rnd[24:20]};
        end else if (f3 == F3_SR) begin
          imm = {rnd[15] ? ALT : 7'b0, rnd[24:20]};
        end else begin
          imm = rnd[31:20];
        end
        issue(enc_i(imm, rs1, f3, rd));
      end else begin
        issue(enc_lui(rnd[31:12], rd));
      end
    end
    drain();
  endtask

  initial begin
    i_rst        = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    for (int r = 0; r < 32; r++) begin
      ref_regs[r] = '0;
    end
    reset_quiet();
    imm_and_lui_ops();
    reg_reg_ops();
    dependence_chains();
    illegal_encodings();
    random_stream();
    idle(4);
    end_run();
  end

endmodule

/* rv_core.f */
src/rv_core_pkg.sv
src/rv_dec_ex_if.sv
src/rv_ex_res_if.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core.sv
verif/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_core_pkg.sv
  - src/rv_dec_ex_if.sv
  - src/rv_ex_res_if.sv
  - src/rv_regfile.sv
  - src/rv_decode.sv
  - src/rv_execute.sv
  - src/rv_result.sv
  - src/rv_core.sv
  - target: simulation
    files:
      - verif/rv_core_tb.sv
